// ==== Bender.yml ====
package:
  name: noc_perm_bridge

sources:
  - files:
      - hdl/noc_pkg.sv
      - hdl/perm_pkg.sv
      - hdl/len_counter.sv
      - hdl/noc_rx_fsm.sv
      - hdl/state_buffer.sv
      - hdl/noc_resp_tx.sv
      - hdl/noc_perm_bridge.sv
  - target: simulation
    files:
      - bench/tb_noc_perm_bridge.sv

// ==== all.f ====
hdl/noc_pkg.sv
hdl/perm_pkg.sv
hdl/len_counter.sv
hdl/noc_rx_fsm.sv
hdl/state_buffer.sv
hdl/noc_resp_tx.sv
hdl/noc_perm_bridge.sv
bench/tb_noc_perm_bridge.sv

// ==== bench/tb_noc_perm_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_noc_perm_bridge
	import noc_pkg::*;
	import perm_pkg::*;
;

	localparam int LANES = 25;
	localparam int TOTAL = LANES * 8;
	localparam int LIMIT = 4000; // Cycles allowed for any single wait

	logic  clk;
	logic  rst;
	logic  noc_to_dev_ctl;
	byte_t noc_to_dev_data;
	logic  noc_from_dev_ctl;
	byte_t noc_from_dev_data;
	logic  pushin;
	logic  firstin;
	lane_t din;
	logic  stopin;

	integer   seed;
	int       errors;
	int       checks;
	byte_t    model_mem [TOTAL]; // Bytes the buffer should hold
	int       model_fill;
	int       lane_idx;
	int       drains_done;
	byte_t    exp_q [$];         // Response bytes still to come
	node_id_t last_dest;
	node_id_t last_src;

	noc_perm_bridge #(.LANES(LANES)) UUT (
		.clk               (clk),
		.rst               (rst),
		.noc_to_dev_ctl    (noc_to_dev_ctl),
		.noc_to_dev_data   (noc_to_dev_data),
		.noc_from_dev_ctl  (noc_from_dev_ctl),
		.noc_from_dev_data (noc_from_dev_data),
		.pushin            (pushin),
		.firstin           (firstin),
		.din               (din),
		.stopin            (stopin)
	);

	always #20 clk = ~clk;

	task automatic check_lane(input lane_t got, input lane_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp_byte(input byte_t got, input byte_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Lane i carries bytes 8i to 8i+7, lowest byte at the bottom
	function automatic lane_t exp_lane(input int idx);
		lane_t r;
		for (int b = 0; b < 8; b++)
			r[8*b +: 8] = model_mem[8*idx + b];
		return r;
	endfunction

	function automatic byte_t exp_resp(input resp_kind_e kind, input rc_t rc, input node_id_t dest,
		input node_id_t src, input byte_t len, input int idx);
		case (idx)
			0:       return (kind == RESP_ERROR) ? 8'h05 : {rc, 6'd4};
			1:       return dest;
			2:       return src;
			3:       return (kind == RESP_ERROR) ? 8'h42 : len;
			default: return 8'h03;
		endcase
	endfunction

	task automatic queue_resp(input resp_kind_e kind, input rc_t rc, input node_id_t dest,
		input node_id_t src, input byte_t len);
		int n;
		n = (kind == RESP_ERROR) ? 5 : 4;
		for (int i = 0; i < n; i++)
			exp_q.push_back(exp_resp(kind, rc, dest, src, len, i));
	endtask

	task automatic drive_byte(input logic ctl, input byte_t b);
		@(negedge clk);
		noc_to_dev_ctl  = ctl;
		noc_to_dev_data = b;
	endtask

	task automatic make_data(input int n, output byte_t q [$]);
		q = {};
		for (int i = 0; i < n; i++)
			q.push_back(byte_t'($random(seed)));
	endtask

	task automatic send_write(input node_id_t dest, input node_id_t src, input alen_code_t alen,
		input len_code_t dlen, input byte_t data [$]);
		logic bad_id;
		logic dropped;
		int   accepted;
		bad_id   = 1'b0;
		dropped  = 1'b0;
		accepted = 0;
		drive_byte(1'b1, {alen, dlen, 3'd2});
		drive_byte(1'b0, dest);
		last_dest = dest;
		if (dest == 8'd0) begin
			bad_id = 1'b1;
			queue_resp(RESP_ERROR, 2'd0, dest, last_src, 8'd0);
		end
		drive_byte(1'b0, src);
		if (!bad_id) begin
			last_src = src;
			if (src == 8'd0) begin
				bad_id = 1'b1;
				queue_resp(RESP_ERROR, 2'd0, last_dest, src, 8'd0);
			end
		end
		for (int i = 0; i < (1 << alen); i++)
			drive_byte(1'b0, byte_t'(8'hc0 + i)); // Address bytes, never stored
		for (int i = 0; i < data.size(); i++) begin
			drive_byte(1'b0, data[i]);
			if (!bad_id && model_fill < TOTAL) begin
				model_mem[model_fill] = data[i];
				model_fill++;
				accepted++;
			end else if (!bad_id) begin
				dropped = 1'b1; // Buffer full or draining
			end
		end
		if (!bad_id)
			queue_resp(RESP_WRITE, dropped ? 2'd2 : 2'd0, src, dest, byte_t'(accepted));
		drive_byte(1'b0, 8'h00);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Something failed");
		$finish;
	endtask

	// Optionally stalls the drain with a random stopin pattern
	task automatic wait_drains(input int target, input logic random_stop);
		int cycles;
		cycles = 0;
		while (drains_done < target && cycles < LIMIT) begin
			@(negedge clk);
			stopin = random_stop ? logic'($random(seed)) : 1'b0;
			cycles++;
		end
		stopin = 1'b0;
		if (drains_done < target)
			abort_on_timeout("the permutation drain to finish");
	endtask

	task automatic wait_responses();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0)
			abort_on_timeout("the outgoing response bytes");
	endtask

	task automatic check_idle_outputs(input string when);
		check_flag(noc_from_dev_ctl, 1'b0, {"noc_from_dev_ctl ", when});
		check_resp_byte(noc_from_dev_data, 8'h00, {"noc_from_dev_data ", when});
		check_flag(pushin, 1'b0, {"pushin ", when});
		check_flag(firstin, 1'b0, {"firstin ", when});
		check_lane(din, '0, {"din ", when});
	endtask

	task automatic report(input string name, input int err_mark);
		$display("%s: %s, %0d errors", name, (errors == err_mark) ? "passed" : "failed",
			errors - err_mark);
	endtask

	initial begin : lane_monitor
		forever begin
			@(posedge clk);
			#1;
			if (pushin) begin
				if (stopin) begin
					errors++;
					$display("[FAIL] %0t ns: pushin high in a cycle with stopin high", $time);
				end
				if (model_fill != TOTAL) begin
					errors++;
					$display("[FAIL] %0t ns: lane pushed before the buffer was full", $time);
				end
				check_lane(din, exp_lane(lane_idx), $sformatf("lane %0d", lane_idx));
				check_flag(firstin, lane_idx == 0, $sformatf("firstin of lane %0d", lane_idx));
				lane_idx++;
				if (lane_idx == LANES) begin
					lane_idx    = 0;
					model_fill  = 0; // Buffer opens again after the last lane
					drains_done++;
				end
			end else begin
				check_flag(firstin, 1'b0, "firstin without pushin");
			end
		end
	end

	initial begin : resp_monitor
		int remaining;
		remaining = 0;
		forever begin
			@(posedge clk);
			#1;
			if (noc_from_dev_ctl || remaining > 0) begin
				check_flag(noc_from_dev_ctl, remaining == 0, "response ctl");
				if (exp_q.size() == 0) begin
					errors++;
					$display("Response byte %h came out when none was expected", noc_from_dev_data);
				end else begin
					check_resp_byte(noc_from_dev_data, exp_q.pop_front(), "response byte");
				end
				if (remaining == 0)
					remaining = (noc_from_dev_data == 8'h05) ? 4 : 3;
				else
					remaining--;
			end else if (noc_from_dev_data != 8'h00) begin
				errors++;
				$display("Outgoing data %h while the link was idle", noc_from_dev_data);
			end
		end
	end

	initial begin : main
		byte_t pkt [$];
		int    err_mark;
		clk             = 1'b0;
		rst             = 1'b1;
		noc_to_dev_ctl  = 1'b0;
		noc_to_dev_data = 8'h00;
		stopin          = 1'b0;
		seed            = 32'hd0b0;
		errors          = 0;
		checks          = 0;
		model_fill      = 0;
		lane_idx        = 0;
		drains_done     = 0;
		last_dest       = 8'h00;
		last_src        = 8'h00;
		repeat (5) @(negedge clk);

		err_mark = errors;
		check_idle_outputs("in reset");
		rst = 1'b0;
		repeat (4) drive_byte(1'b0, 8'ha5); // Stray bytes outside a packet
		drive_byte(1'b1, {2'd0, 3'd2, 3'd1}); // Read header
		repeat (7) drive_byte(1'b0, 8'h3c);
		drive_byte(1'b0, 8'h00);
		repeat (20) @(negedge clk);
		check_idle_outputs("after ignored traffic");
		report("Test 6 reset and ignored traffic", err_mark);

		err_mark = errors;
		make_data(128, pkt);
		send_write(8'h11, 8'h22, 2'd0, 3'd7, pkt);
		make_data(64, pkt);
		send_write(8'h33, 8'h44, 2'd1, 3'd6, pkt);
		make_data(8, pkt);
		send_write(8'h55, 8'h66, 2'd3, 3'd3, pkt);
		wait_drains(1, 1'b0);
		report("Test 1 lanes from three packets", err_mark);
		wait_responses();
		report("Test 2 write responses", err_mark);

		err_mark = errors;
		make_data(128, pkt);
		send_write(8'h21, 8'h12, 2'd0, 3'd7, pkt);
		make_data(64, pkt);
		send_write(8'h43, 8'h34, 2'd1, 3'd6, pkt);
		make_data(16, pkt); // Half of it lands past the 200th byte
		send_write(8'h65, 8'h56, 2'd2, 3'd4, pkt);
		wait_drains(2, 1'b0);
		wait_responses();
		report("Test 3 overflow drops", err_mark);

		err_mark = errors;
		make_data(4, pkt);
		send_write(8'h00, 8'h77, 2'd0, 3'd2, pkt);
		make_data(4, pkt);
		send_write(8'h12, 8'h00, 2'd0, 3'd2, pkt);
		wait_responses();
		report("Test 5 zero ID errors", err_mark);

		// Lanes of this fill also show that the error packets stored nothing
		err_mark = errors;
		make_data(128, pkt);
		send_write(8'h0a, 8'h0b, 2'd0, 3'd7, pkt);
		make_data(64, pkt);
		send_write(8'h0c, 8'h0d, 2'd1, 3'd6, pkt);
		make_data(8, pkt);
		send_write(8'h0e, 8'h0f, 2'd3, 3'd3, pkt);
		wait_drains(3, 1'b1);
		wait_responses();
		report("Test 4 drain under random stopin", err_mark);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/len_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module len_counter #(
	parameter int WIDTH = 8
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              load,
	input  wire [WIDTH-1:0]  load_value,
	input  wire              step,
	output logic [WIDTH-1:0] count,
	output logic             last
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (load) begin
			count <= load_value; // Load wins over step
		end else if (step && count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign last = (count == WIDTH'(1));

	// The controller stops stepping once its field or drain has run out
	assert property (@(posedge clk) disable iff (rst) step && !load |-> count != '0)
		else $error("len_counter stepped with count at zero");

endmodule

`default_nettype wire

// ==== hdl/noc_perm_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_perm_bridge
	import noc_pkg::*;
	import perm_pkg::*;
#(
	parameter int LANES = LANES_DEFAULT
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        noc_to_dev_ctl,
	input  wire byte_t noc_to_dev_data,
	output logic       noc_from_dev_ctl,
	output byte_t      noc_from_dev_data,
	output logic       pushin,
	output logic       firstin,
	output lane_t      din,
	input  wire        stopin
);

	localparam int LANE_W = $clog2(LANES + 1);

	logic              field_load;
	logic              field_step;
	logic              field_last;
	byte_t             field_count;
	logic              wr_en;
	byte_t             wr_byte;
	logic              buf_full;
	logic              resp_valid;
	resp_req_t         resp;
	logic              drain_load;
	logic              drain_step;
	logic [LANE_W-1:0] lane_count;

	noc_rx_fsm u_rx (
		.clk             (clk),
		.rst             (rst),
		.noc_to_dev_ctl  (noc_to_dev_ctl),
		.noc_to_dev_data (noc_to_dev_data),
		.field_last      (field_last),
		.field_load      (field_load),
		.field_count     (field_count),
		.field_step      (field_step),
		.buf_full        (buf_full),
		.wr_en           (wr_en),
		.wr_byte         (wr_byte),
		.resp_valid      (resp_valid),
		.resp            (resp)
	);

	// Field lengths of the packet being parsed
	len_counter #(.WIDTH($bits(byte_t))) u_field (
		.clk        (clk),
		.rst        (rst),
		.load       (field_load),
		.load_value (field_count),
		.step       (field_step),
		.count      (),
		.last       (field_last)
	);

	// Lanes still to go out during a drain
	len_counter #(.WIDTH(LANE_W)) u_lane (
		.clk        (clk),
		.rst        (rst),
		.load       (drain_load),
		.load_value (LANE_W'(LANES)),
		.step       (drain_step),
		.count      (lane_count),
		.last       ()
	);

	state_buffer #(.LANES(LANES)) u_buf (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (wr_en),
		.wr_byte    (wr_byte),
		.full       (buf_full),
		.drain_load (drain_load),
		.drain_step (drain_step),
		.lane_count (lane_count),
		.stopin     (stopin),
		.pushin     (pushin),
		.firstin    (firstin),
		.din        (din)
	);

	noc_resp_tx u_tx (
		.clk               (clk),
		.rst               (rst),
		.resp_valid        (resp_valid),
		.resp              (resp),
		.noc_from_dev_ctl  (noc_from_dev_ctl),
		.noc_from_dev_data (noc_from_dev_data)
	);

endmodule

`default_nettype wire

// ==== hdl/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] node_id_t;   // Zero is never a valid node
	typedef logic [2:0] len_code_t;  // 1 to 128 bytes
	typedef logic [1:0] alen_code_t; // 1, 2, 4 or 8 bytes
	typedef logic [1:0] rc_t;

	typedef enum logic [2:0] {
		CMD_NOP   = 3'd0,
		CMD_READ  = 3'd1,
		CMD_WRITE = 3'd2
	} cmd_e;

	// Header byte as it arrives, alen in the top bits
	typedef struct packed {
		alen_code_t alen;
		len_code_t  dlen;
		cmd_e       cmd;
	} noc_hdr_t;

	typedef enum logic {
		RESP_WRITE,
		RESP_ERROR
	} resp_kind_e;

	typedef struct packed {
		resp_kind_e kind;
		rc_t        rc;
		node_id_t   dest;
		node_id_t   src;
		byte_t      length; // Accepted data bytes
	} resp_req_t;

	localparam rc_t RC_OK      = 2'd0;
	localparam rc_t RC_DROPPED = 2'd2;

	localparam logic [5:0] HDR_WRITE_RESP = 6'd4;
	localparam byte_t      HDR_ERROR_MSG  = 8'd5;
	localparam byte_t      MSG_ADDR       = 8'h42;
	localparam byte_t      MSG_ERR_ID     = 8'h03;

	function automatic byte_t decode_alen(alen_code_t code);
		return byte_t'(1) << code;
	endfunction

	function automatic byte_t decode_dlen(len_code_t code);
		return byte_t'(1) << code;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/noc_resp_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_resp_tx
	import noc_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire            resp_valid,
	input  wire resp_req_t resp,
	output logic           noc_from_dev_ctl,
	output byte_t          noc_from_dev_data
);

	typedef enum logic {
		TX_IDLE,
		TX_BODY
	} tx_state_e;

	tx_state_e  state;
	resp_req_t  req;
	logic [2:0] idx;      // Body byte to send next
	logic [2:0] last_idx;
	byte_t      hdr_byte;
	byte_t      body_byte;

	// Write response is 4 bytes, error message 5
	assign last_idx = (req.kind == RESP_ERROR) ? 3'd4 : 3'd3;

	assign hdr_byte = (resp.kind == RESP_ERROR) ? HDR_ERROR_MSG : {resp.rc, HDR_WRITE_RESP};

	always_comb begin
		case (idx)
			3'd1:    body_byte = req.dest;
			3'd2:    body_byte = req.src;
			3'd3:    body_byte = (req.kind == RESP_ERROR) ? MSG_ADDR : req.length;
			default: body_byte = MSG_ERR_ID;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resp_valid)
			req <= resp;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state             <= TX_IDLE;
			idx               <= '0;
			noc_from_dev_ctl  <= 1'b0;
			noc_from_dev_data <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (resp_valid) begin
						noc_from_dev_ctl  <= 1'b1; // Header
						noc_from_dev_data <= hdr_byte;
						idx               <= 3'd1;
						state             <= TX_BODY;
					end else begin
						noc_from_dev_ctl  <= 1'b0;
						noc_from_dev_data <= '0;
					end
				end
				TX_BODY: begin
					noc_from_dev_ctl  <= 1'b0;
					noc_from_dev_data <= body_byte;
					idx               <= idx + 1'b1;
					if (idx == last_idx)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Incoming packets are at least 5 bytes, so requests never overlap a response
	assert property (@(posedge clk) disable iff (rst) resp_valid |-> state == TX_IDLE)
		else $error("response request arrived while a response was still going out");

endmodule

`default_nettype wire

// ==== hdl/noc_rx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_rx_fsm
	import noc_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire        noc_to_dev_ctl,
	input  wire byte_t noc_to_dev_data,
	input  wire        field_last,
	output logic       field_load,
	output byte_t      field_count,
	output logic       field_step,
	input  wire        buf_full,
	output logic       wr_en,
	output byte_t      wr_byte,
	output logic       resp_valid,
	output resp_req_t  resp
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DEST,
		ST_SRC,
		ST_ADDR,
		ST_DATA
	} rx_state_e;

	rx_state_e state;
	noc_hdr_t  hdr_in;
	noc_hdr_t  hdr_q;
	node_id_t  dest_id;
	node_id_t  src_id;
	byte_t     acc_cnt;   // Bytes the buffer took in this packet
	byte_t     acc_next;
	logic      drop_seen;
	logic      drop_next;
	logic      id_zero;

	assign hdr_in  = noc_hdr_t'(noc_to_dev_data);
	assign id_zero = (noc_to_dev_data == '0);

	// Address length goes in on a good source byte, data length on the last address byte
	assign field_load  = (state == ST_SRC && !id_zero) || (state == ST_ADDR && field_last);
	assign field_count = (state == ST_ADDR) ? decode_dlen(hdr_q.dlen) : decode_alen(hdr_q.alen);
	assign field_step  = (state == ST_ADDR || state == ST_DATA) && !field_load;

	assign wr_en   = (state == ST_DATA);
	assign wr_byte = noc_to_dev_data;

	// The buffer drops anything offered while full or draining
	assign acc_next  = buf_full ? acc_cnt : acc_cnt + 1'b1;
	assign drop_next = drop_seen || buf_full;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= ST_IDLE;
			hdr_q      <= '0;
			dest_id    <= '0;
			src_id     <= '0;
			acc_cnt    <= '0;
			drop_seen  <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Stray data bytes and read headers fall through here
					if (noc_to_dev_ctl && hdr_in.cmd == CMD_WRITE) begin
						hdr_q     <= hdr_in;
						acc_cnt   <= '0;
						drop_seen <= 1'b0;
						state     <= ST_DEST;
					end
				end
				ST_DEST: begin
					dest_id <= noc_to_dev_data;
					if (id_zero) begin
						resp_valid <= 1'b1; // Error message
						state      <= ST_IDLE;
					end else begin
						state <= ST_SRC;
					end
				end
				ST_SRC: begin
					src_id <= noc_to_dev_data;
					if (id_zero) begin
						resp_valid <= 1'b1;
						state      <= ST_IDLE;
					end else begin
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (field_last)
						state <= ST_DATA; // Address bytes are only counted
				end
				ST_DATA: begin
					acc_cnt   <= acc_next;
					drop_seen <= drop_next;
					if (field_last) begin
						resp_valid <= 1'b1;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_DEST && id_zero) begin
			resp <= '{kind: RESP_ERROR, rc: RC_OK, dest: noc_to_dev_data,
				src: src_id, length: '0};
		end else if (state == ST_SRC && id_zero) begin
			resp <= '{kind: RESP_ERROR, rc: RC_OK, dest: dest_id,
				src: noc_to_dev_data, length: '0};
		end else if (state == ST_DATA && field_last) begin
			// Response goes back to the sender, so the IDs swap
			resp <= '{kind: RESP_WRITE, rc: (drop_next ? RC_DROPPED : RC_OK),
				dest: src_id, src: dest_id, length: acc_next};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/perm_pkg.sv ====
`default_nettype none

package perm_pkg;

	localparam int LANE_BYTES = 8;

	// 25 lanes make up the 200-byte permutation state
	localparam int LANES_DEFAULT = 25;

	// One word on the permutation port
	typedef logic [LANE_BYTES*8-1:0] lane_t;

	// Same word seen as bytes, byte 0 in bits 7:0
	typedef logic [LANE_BYTES-1:0][7:0] lane_bytes_t;

endpackage

`default_nettype wire

// ==== hdl/state_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module state_buffer
	import noc_pkg::*;
	import perm_pkg::*;
#(
	parameter int LANES = LANES_DEFAULT,
	localparam int LANE_W = $clog2(LANES + 1)
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              wr_en,
	input  wire byte_t       wr_byte,
	output logic             full,
	output logic             drain_load,
	output logic             drain_step,
	input  wire [LANE_W-1:0] lane_count,
	input  wire              stopin,
	output logic             pushin,
	output logic             firstin,
	output lane_t            din
);

	localparam int TOTAL  = LANES * LANE_BYTES;
	localparam int FILL_W = $clog2(TOTAL + 1);

	lane_bytes_t       mem [LANES];
	logic [FILL_W-1:0] fill;
	logic [LANE_W-1:0] lane_idx;
	logic              accept;
	logic              draining;

	// Fill stays at TOTAL until the last lane leaves, so full covers the drain too
	assign full   = (fill == FILL_W'(TOTAL));
	assign accept = wr_en && !full;

	assign drain_load = accept && (fill == FILL_W'(TOTAL - 1)); // Lane count starts at LANES
	assign draining   = full && (lane_count != '0);
	assign drain_step = draining && !stopin;
	assign lane_idx   = LANE_W'(LANES) - lane_count;

	always_ff @(posedge clk) begin
		if (accept)
			mem[fill / LANE_BYTES][fill % LANE_BYTES] <= wr_byte;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fill <= '0;
		end else if (accept) begin
			fill <= fill + 1'b1;
		end else if (drain_step && lane_count == LANE_W'(1)) begin
			fill <= '0; // Last lane out, open for new bytes
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pushin  <= 1'b0;
			firstin <= 1'b0;
			din     <= '0;
		end else begin
			pushin  <= drain_step;
			firstin <= drain_step && (lane_count == LANE_W'(LANES));
			din     <= drain_step ? lane_t'(mem[lane_idx]) : '0;
		end
	end

	// A lane is only launched on a clock where the permutation block was not stalling
	assert property (@(posedge clk) disable iff (rst) pushin |-> !$past(stopin))
		else $error("pushin raised for a cycle with stopin high");

endmodule

`default_nettype wire
